/* list.f */
hdl/exu_pkg.sv
hdl/rv_decoder.sv
hdl/alu.sv
hdl/branch_cond.sv
hdl/exu.sv
hdl/exec_top.sv
bench/exec_tb.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" &&
verilator --binary --timing -f list.f --top-module exec_tb -o exec_sim &&
./obj_dir/exec_sim | tee /dev/stderr | grep -q "Result: PASSED" ||
exit 1

/* bench/exec_tb.sv */
`timescale 1ns/1ns

module exec_tb
	import exu_pkg::*;
();

	logic clock = 1'b0;
	logic rst_n;
	logic [31:0] inst, src1, src2, pc, dnpc, csr_jump, csr_val;
	logic csr_jump_en, exu_valid, exu_ready;
	exu_result_t result;
	logic jump_wrong, btb_wvalid, lsu_ren, lsu_wen, csr_enable;
	logic [31:0] val, csr_wdata;
	logic [4:0] rs1, rs2;
	string tname;
	int errs = 0, err0 = 0, n_pass = 0, n_fail = 0, cycles = 0;

	exec_top dut (.*);

	always #50 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= 2000) begin
			$display("timeout: run did not finish within %0d cycles", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] alu_model(logic [2:0] f3, logic alt, logic [31:0] a, b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic taken_model(logic [2:0] f3, logic [31:0] a, b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic logic [31:0] sext12(logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] r2, r1, logic [2:0] f3);
		return {imm[12], imm[10:5], r2, r1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("Fail %s %s expected %h actual %h", tname, what, exp, act);
			errs++;
		end
	endtask

	task automatic check1(input string what, input logic exp, input logic act);
		assert (exp === act) else begin
			$display("Fail %s %s expected %b actual %b", tname, what, exp, act);
			errs++;
		end
	endtask

	task automatic check_result(input string what, input exu_result_t exp,
		input exu_result_t act);
		assert (exp === act) else begin
			$display("Fail %s %s expected %h actual %h", tname, what, exp, act);
			errs++;
		end
	endtask

	// drive on the falling edge and let outputs settle
	task automatic issue(input logic [31:0] i, s1, s2, p, dn, input logic cen,
		input logic [31:0] cj);
		@(negedge clock);
		inst = i;
		src1 = s1;
		src2 = s2;
		pc = p;
		dnpc = dn;
		csr_jump_en = cen;
		csr_jump = cj;
		exu_valid = 1'b1;
		exu_ready = 1'b1;
		#1;
	endtask

	task automatic commit();
		@(posedge clock);
		#1;
	endtask

	task automatic open_test(input string name);
		tname = name;
		err0 = errs;
	endtask

	task automatic close_test();
		if (errs == err0) n_pass++;
		else n_fail++;
		$display("test %s: %0d errors", tname, errs - err0);
	endtask

	initial begin
		logic [31:0] r, a, b, p, exp, npc, dn, tgt, off, iw;
		logic [11:0] imm;
		logic [2:0] f3;
		logic alt, is_jal;
		exu_result_t exp_res;
		void'($urandom(32'hdad0));
		rst_n = 1'b0;
		inst = 32'h13;
		src1 = '0;
		src2 = '0;
		pc = '0;
		dnpc = 32'd4;
		csr_jump = '0;
		csr_val = '0;
		csr_jump_en = 1'b0;
		exu_valid = 1'b0;
		exu_ready = 1'b0;
		repeat (2) @(posedge clock);
		@(negedge clock) rst_n = 1'b1;

		open_test("alu");
		for (int n = 0; n < 300; n++) begin
			r = $urandom;
			a = $urandom;
			b = $urandom;
			p = $urandom & 32'hffff_fffc;
			if (n[0]) a[31] = 1'b1; // negative operands for sra and slt
			f3 = r[14:12];
			if (n % 10 < 5) begin
				alt = r[30] & ((f3 == 3'd5) | (f3 == 3'd0));
				iw = {1'b0, alt, 5'b0, r[24:20], r[19:15], f3, r[11:7], 7'b0110011};
				exp = alu_model(f3, alt, a, b);
			end else if (n % 10 < 8) begin
				alt = r[30] & (f3 == 3'd5);
				imm = (f3 == 3'd1) ? {7'b0, r[24:20]} :
					(f3 == 3'd5) ? {1'b0, alt, 5'b0, r[24:20]} : r[31:20];
				iw = {imm, r[19:15], f3, r[11:7], 7'b0010011};
				exp = alu_model(f3, alt, a, sext12(imm));
			end else if (n % 10 == 8) begin
				iw = {r[31:12], r[11:7], 7'b0110111};
				exp = {r[31:12], 12'b0};
			end else begin
				iw = {r[31:12], r[11:7], 7'b0010111};
				exp = p + {r[31:12], 12'b0};
			end
			issue(iw, a, b, p, p + 32'd4, 1'b0, '0);
			check("val", exp, val);
			check1("lsu_ren", 1'b0, lsu_ren);
			check1("lsu_wen", 1'b0, lsu_wen);
			check1("csr_enable", 1'b0, csr_enable);
			commit();
			check("rd", {27'b0, r[11:7]}, {27'b0, result.rd});
			check("pc_low", {7'b0, p[24:0]}, {7'b0, result.pc_low});
			check1("jump_wrong", 1'b0, jump_wrong);
		end
		close_test();

		open_test("branch");
		for (int n = 0; n < 400; n++) begin
			r = $urandom;
			a = $urandom;
			p = $urandom & 32'hffff_fffc;
			b = r[3] ? a : $urandom; // hit the equal case often
			f3 = (r[2:0] % 3'd6 < 3'd2) ? r[2:0] % 3'd6 : r[2:0] % 3'd6 + 3'd2;
			off = {{19{r[31]}}, r[31:20], 1'b0};
			tgt = p + off;
			npc = taken_model(f3, a, b) ? tgt : p + 32'd4;
			dn = r[4] ? tgt : p + 32'd4;
			issue(enc_b(off[12:0], r[9:5], r[14:10], f3), a, b, p, dn, 1'b0, '0);
			commit();
			check("jump_addr", npc, result.jump_addr);
			check1("jump_wrong", npc != dn, jump_wrong);
			check1("btb_wvalid", (npc != dn) & off[31], btb_wvalid);
		end
		close_test();

		open_test("jump");
		for (int n = 0; n < 200; n++) begin
			r = $urandom;
			a = $urandom;
			p = $urandom & 32'hffff_fffc;
			is_jal = r[0];
			if (is_jal) begin
				off = {{11{r[31]}}, r[31:12], 1'b0};
				tgt = p + off;
				iw = {off[20], off[10:1], off[11], off[19:12], r[11:7], 7'b1101111};
			end else begin
				tgt = a + sext12(r[31:20]);
				iw = {r[31:20], r[19:15], 3'b000, r[11:7], 7'b1100111};
			end
			dn = r[1] ? tgt : tgt + 32'd4;
			issue(iw, a, '0, p, dn, 1'b0, '0);
			check("val", p + 32'd4, val);
			commit();
			check("jump_addr", tgt, result.jump_addr);
			check1("jump_wrong", !r[1], jump_wrong);
			check1("btb_wvalid", !r[1] & is_jal, btb_wvalid);
		end
		close_test();

		open_test("load_store");
		for (int n = 0; n < 200; n++) begin
			r = $urandom;
			a = $urandom;
			p = $urandom & 32'hffff_fffc;
			if (r[0])
				iw = {r[31:20], r[19:15], 3'b010, r[11:7], 7'b0000011};
			else
				iw = {r[31:25], r[24:20], r[19:15], 3'b010, r[11:7], 7'b0100011};
			exp = r[0] ? a + sext12(r[31:20]) : a + sext12({r[31:25], r[11:7]});
			issue(iw, a, $urandom, p, p + 32'd4, 1'b0, '0);
			check("val", exp, val);
			check1("lsu_ren", r[0], lsu_ren);
			check1("lsu_wen", !r[0], lsu_wen);
			check("rs1", {27'b0, r[19:15]}, {27'b0, rs1});
			check("rs2", {27'b0, r[24:20]}, {27'b0, rs2});
			commit();
			check1("reg_wen", r[0], result.reg_wen);
			check1("jump_wrong", 1'b0, jump_wrong);
		end
		close_test();

		open_test("csr");
		for (int n = 0; n < 200; n++) begin
			r = $urandom;
			a = $urandom;
			p = $urandom & 32'hffff_fffc;
			@(negedge clock) csr_val = $urandom;
			if (n % 4 == 3) begin
				issue({17'b0, 3'b001, 12'b0001111}, a, '0, p, p + 32'd4, 1'b0, '0);
				commit();
				check1("fence.i jump_wrong", 1'b1, jump_wrong);
				check1("fence.i btb_wvalid", 1'b0, btb_wvalid);
			end else begin
				f3 = 3'd1 + {1'b0, r[13:12] % 2'd3};
				tgt = $urandom & 32'hffff_fffc;
				iw = {r[31:20], r[19:15], f3, r[11:7], 7'b1110011};
				issue(iw, a, '0, p, p + 32'd4, r[0], tgt);
				exp = (f3 == 3'd1) ? a : (f3 == 3'd2) ? (a | csr_val) : 32'd0;
				check("csr_wdata", exp, csr_wdata);
				check("val", csr_val, val);
				check1("csr_enable", 1'b1, csr_enable);
				npc = r[0] ? tgt : p + 32'd4;
				commit();
				check("jump_addr", npc, result.jump_addr);
				check1("jump_wrong", npc != p + 32'd4, jump_wrong);
			end
		end
		close_test();

		open_test("hold_reset");
		p = 32'h0000_1000;
		issue({1'b0, 10'd4, 1'b0, 8'd0, 5'd1, 7'b1101111}, '0, '0, p, p + 32'd4, 1'b0, '0);
		commit();
		exp_res.rd = 5'd1;
		exp_res.pc_low = p[btb_aw-1:0];
		exp_res.reg_wen = 1'b1;
		exp_res.jump_addr = p + 32'd8;
		check_result("jal result", exp_res, result);
		check1("jal mispredict", 1'b1, jump_wrong);
		@(negedge clock) begin
			inst = 32'h0010_0093;
			pc = 32'h40;
			exu_valid = 1'b0;
		end
		commit();
		check_result("result held, valid low", exp_res, result);
		check1("jump_wrong, valid low", 1'b0, jump_wrong);
		@(negedge clock) begin
			exu_valid = 1'b1;
			exu_ready = 1'b0;
		end
		commit();
		check_result("result held, ready low", exp_res, result);
		check1("jump_wrong, ready low", 1'b0, jump_wrong);
		@(negedge clock) begin
			inst = {1'b0, 10'd4, 1'b0, 8'd0, 5'd1, 7'b1101111};
			pc = p;
			exu_valid = 1'b1;
			exu_ready = 1'b1;
			rst_n = 1'b0;
		end
		repeat (2) commit();
		check1("jump_wrong after reset", 1'b0, jump_wrong);
		check1("btb_wvalid after reset", 1'b0, btb_wvalid);
		check_result("result after reset", '0, result);
		@(negedge clock) rst_n = 1'b1;
		close_test();

		$display("tests passed %0d, tests failed %0d", n_pass, n_fail);
		if (errs == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* hdl/exec_top.sv */
`timescale 1ns/1ns

module exec_top
	import exu_pkg::*;
(
	input  logic            clock,
	input  logic            rst_n,
	input  logic [xlen-1:0] inst,
	input  logic [xlen-1:0] src1,
	input  logic [xlen-1:0] src2,
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] dnpc,
	input  logic [xlen-1:0] csr_jump,
	input  logic [xlen-1:0] csr_val,
	input  logic            csr_jump_en,
	input  logic            exu_valid,
	input  logic            exu_ready,
	output exu_result_t     result,
	output logic            jump_wrong,
	output logic            btb_wvalid,
	output logic [xlen-1:0] val,
	output logic [xlen-1:0] csr_wdata,
	output logic            lsu_ren,
	output logic            lsu_wen,
	output logic            csr_enable,
	output logic [4:0]      rs1,
	output logic [4:0]      rs2
);

	dec_bundle_t dec;

	rv_decoder u_dec (
		.inst (inst),
		.dec  (dec),
		.rs1  (rs1),
		.rs2  (rs2)
	);

	exu u_exu (
		.clock       (clock),
		.rst_n       (rst_n),
		.dec         (dec),
		.src1        (src1),
		.src2        (src2),
		.pc          (pc),
		.dnpc        (dnpc),
		.csr_jump    (csr_jump),
		.csr_val     (csr_val),
		.csr_jump_en (csr_jump_en),
		.exu_valid   (exu_valid),
		.exu_ready   (exu_ready),
		.result      (result),
		.jump_wrong  (jump_wrong),
		.btb_wvalid  (btb_wvalid),
		.val         (val),
		.csr_wdata   (csr_wdata),
		.lsu_ren     (lsu_ren),
		.lsu_wen     (lsu_wen),
		.csr_enable  (csr_enable)
	);

endmodule

/* hdl/exu.sv */
`timescale 1ns/1ns

module exu
	import exu_pkg::*;
(
	input  logic            clock,
	input  logic            rst_n,
	input  dec_bundle_t     dec,
	input  logic [xlen-1:0] src1,
	input  logic [xlen-1:0] src2,
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] dnpc,
	input  logic [xlen-1:0] csr_jump,
	input  logic [xlen-1:0] csr_val,
	input  logic            csr_jump_en,
	input  logic            exu_valid,
	input  logic            exu_ready,
	output exu_result_t     result,
	output logic            jump_wrong,
	output logic            btb_wvalid,
	output logic [xlen-1:0] val,
	output logic [xlen-1:0] csr_wdata,
	output logic            lsu_ren,
	output logic            lsu_wen,
	output logic            csr_enable
);

	logic [xlen-1:0] lop;
	logic [xlen-1:0] rop;
	logic [xlen-1:0] alu_y;
	logic [xlen-1:0] alu_sum;
	logic [xlen-1:0] snpc;
	logic [xlen-1:0] npc;
	alu_op_e         alu_op;
	logic            cond;
	logic            is_jump;
	logic            jump_en;
	logic            need_btb;
	logic            fire;

	assign fire    = exu_valid & exu_ready;
	assign snpc    = pc + 32'd4;
	assign is_jump = dec.cls[cls_jal] | dec.cls[cls_jalr];
	assign jump_en = is_jump | (dec.cls[cls_branch] & cond);

	assign lop = (dec.cls[cls_auipc] | dec.cls[cls_jal] | dec.cls[cls_branch]) ? pc :
		dec.cls[cls_lui] ? '0 :
		src1;
	assign rop = dec.cls[cls_op] ? src2 : dec.imm;

	always_comb begin
		alu_op = op_add;
		if (dec.cls[cls_opimm] | dec.cls[cls_op]) begin
			case (dec.funct3)
				3'b000:  alu_op = (dec.cls[cls_op] & dec.funct7_5) ? op_sub : op_add;
				3'b001:  alu_op = op_sll;
				3'b010:  alu_op = op_slt;
				3'b011:  alu_op = op_sltu;
				3'b100:  alu_op = op_xor;
				3'b101:  alu_op = dec.funct7_5 ? op_sra : op_srl;
				3'b110:  alu_op = op_or;
				default: alu_op = op_and;
			endcase
		end
	end

	alu u_alu (
		.a   (lop),
		.b   (rop),
		.op  (alu_op),
		.y   (alu_y),
		.sum (alu_sum)
	);

	branch_cond u_bcond (
		.src1   (src1),
		.src2   (src2),
		.funct3 (dec.funct3),
		.cond   (cond)
	);

	// csr trap/return target wins over everything
	assign npc = csr_jump_en ? csr_jump :
		jump_en ? alu_sum :
		snpc;

	assign csr_enable = dec.cls[cls_csr] & (dec.funct3 != 3'b000);
	assign lsu_ren    = dec.cls[cls_load];
	assign lsu_wen    = dec.cls[cls_store];
	assign need_btb   = (dec.cls[cls_branch] & dec.imm[xlen-1]) | dec.cls[cls_jal];

	assign val = is_jump ? snpc :
		csr_enable ? csr_val :
		alu_y; // also the lw/sw address

	assign csr_wdata = (dec.funct3 == 3'b001) ? src1 :
		(dec.funct3 == 3'b010) ? (src1 | csr_val) :
		'0;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			result     <= '0;
			jump_wrong <= 1'b0;
			btb_wvalid <= 1'b0;
		end else if (fire) begin
			result.rd        <= dec.rd;
			result.pc_low    <= pc[btb_aw-1:0];
			result.reg_wen   <= dec.reg_wen;
			result.jump_addr <= npc;
			jump_wrong       <= (npc != dnpc) | dec.fencei;
			btb_wvalid       <= ((npc != dnpc) | dec.fencei) & need_btb;
		end else begin
			jump_wrong <= 1'b0; // pulse lasts one cycle
			btb_wvalid <= 1'b0;
		end
	end

endmodule

/* hdl/branch_cond.sv */
`timescale 1ns/1ns

module branch_cond
	import exu_pkg::*;
(
	input  logic [xlen-1:0] src1,
	input  logic [xlen-1:0] src2,
	input  logic [2:0]      funct3,
	output logic            cond
);

	logic [xlen-1:0] diff;
	logic            borrow;
	logic            equal;
	logic            less;

	assign {borrow, diff} = {1'b0, src1} - {1'b0, src2};
	assign equal          = (diff == '0);
	assign less = (src1[xlen-1] & ~src2[xlen-1]) |
		(~(src1[xlen-1] ^ src2[xlen-1]) & diff[xlen-1]);

	always_comb begin
		case (funct3)
			3'b000:  cond = equal;   // beq
			3'b001:  cond = ~equal;  // bne
			3'b100:  cond = less;    // blt
			3'b101:  cond = ~less;   // bge
			3'b110:  cond = borrow;  // bltu
			3'b111:  cond = ~borrow; // bgeu
			default: cond = 1'b0;
		endcase
	end

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ns

module alu
	import exu_pkg::*;
(
	input  logic [xlen-1:0] a,
	input  logic [xlen-1:0] b,
	input  alu_op_e         op,
	output logic [xlen-1:0] y,
	output logic [xlen-1:0] sum
);

	logic [xlen-1:0] diff;
	logic            borrow;
	logic            less;
	logic [4:0]      shamt;

	assign sum            = a + b;
	assign {borrow, diff} = {1'b0, a} - {1'b0, b};
	assign shamt          = b[4:0];

	// signed compare from the sign bits and the difference
	assign less = (a[xlen-1] & ~b[xlen-1]) | (~(a[xlen-1] ^ b[xlen-1]) & diff[xlen-1]);

	always_comb begin
		case (op)
			op_add:  y = sum;
			op_sub:  y = diff;
			op_and:  y = a & b;
			op_xor:  y = a ^ b;
			op_or:   y = a | b;
			op_srl:  y = a >> shamt;
			op_sra:  y = $unsigned($signed(a) >>> shamt);
			op_sll:  y = a << shamt;
			op_slt:  y = {{(xlen-1){1'b0}}, less};
			op_sltu: y = {{(xlen-1){1'b0}}, borrow}; // borrow means a < b
			default: y = '0;
		endcase
	end

endmodule

/* hdl/rv_decoder.sv */
`timescale 1ns/1ns

module rv_decoder
	import exu_pkg::*;
(
	input  logic [xlen-1:0] inst,
	output dec_bundle_t     dec,
	output logic [4:0]      rs1,
	output logic [4:0]      rs2
);

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		dec.cls    = '0;
		dec.imm    = '0;
		dec.fencei = 1'b0;
		case (opcode)
			7'b0110111: begin
				dec.cls[cls_lui] = 1'b1;
				dec.imm          = imm_u;
			end
			7'b0010111: begin
				dec.cls[cls_auipc] = 1'b1;
				dec.imm            = imm_u;
			end
			7'b1101111: begin
				dec.cls[cls_jal] = 1'b1;
				dec.imm          = imm_j;
			end
			7'b1100111: begin
				dec.cls[cls_jalr] = 1'b1;
				dec.imm           = imm_i;
			end
			7'b1100011: begin
				dec.cls[cls_branch] = 1'b1;
				dec.imm             = imm_b;
			end
			7'b0000011: begin
				dec.cls[cls_load] = 1'b1; // lw only
				dec.imm           = imm_i;
			end
			7'b0100011: begin
				dec.cls[cls_store] = 1'b1; // sw only
				dec.imm            = imm_s;
			end
			7'b0010011: begin
				dec.cls[cls_opimm] = 1'b1;
				dec.imm            = imm_i;
			end
			7'b0110011: begin
				dec.cls[cls_op] = 1'b1;
			end
			7'b1110011: begin
				dec.cls[cls_csr] = 1'b1;
				dec.imm          = imm_i; // csr address
			end
			7'b0001111: begin
				dec.fencei = (funct3 == 3'b001); // misc-mem, fence.i
			end
			default: ;
		endcase
		dec.rd       = inst[11:7];
		dec.funct3   = funct3;
		dec.funct7_5 = inst[30];
		dec.reg_wen  = (|dec.cls) & ~dec.cls[cls_branch] & ~dec.cls[cls_store];
	end

endmodule

/* hdl/exu_pkg.sv */
package exu_pkg;

	localparam int xlen    = 32;
	localparam int btb_aw  = 25; // pc bits kept for btb update
	localparam int n_class = 10;

	// bit positions in the one-hot class vector
	typedef enum logic [3:0] {
		cls_lui    = 4'd0,
		cls_auipc  = 4'd1,
		cls_jal    = 4'd2,
		cls_jalr   = 4'd3,
		cls_branch = 4'd4,
		cls_load   = 4'd5,
		cls_store  = 4'd6,
		cls_opimm  = 4'd7,
		cls_op     = 4'd8,
		cls_csr    = 4'd9
	} inst_class_e;

	typedef enum logic [3:0] {
		op_add  = 4'd0,
		op_sub  = 4'd1,
		op_and  = 4'd2,
		op_xor  = 4'd3,
		op_or   = 4'd4,
		op_srl  = 4'd5,
		op_sra  = 4'd6,
		op_sll  = 4'd7,
		op_slt  = 4'd8,
		op_sltu = 4'd9
	} alu_op_e;

	typedef struct packed {
		logic [n_class-1:0] cls;
		logic [4:0]         rd;
		logic [xlen-1:0]    imm;
		logic [2:0]         funct3;
		logic               funct7_5;
		logic               reg_wen;
		logic               fencei;
	} dec_bundle_t;

	typedef struct packed {
		logic [4:0]        rd;
		logic [btb_aw-1:0] pc_low;
		logic              reg_wen;
		logic [xlen-1:0]   jump_addr; // resolved next-pc
	} exu_result_t;

endpackage
